//--- link_pkg.sv
// UART link package: serial frame constants, bit period type and UART state encodings.
package link_pkg;

	// bits per character on the serial line.
	localparam int DATA_BITS = 8;

	// width of the data bit index.
	localparam int BIT_IDX_W = $clog2(DATA_BITS);

	// one character on the link.
	typedef logic [DATA_BITS-1:0] byte_t;

	// clocks per bit and inter-byte spacing, both in clock cycles.
	typedef logic [9:0] cpd_t;

	// transmitter frame sequence.
	typedef enum logic [2:0] {
		TX_IDLE  = 3'd0,
		TX_START = 3'd1,
		TX_DATA  = 3'd2,
		TX_STOP  = 3'd3,
		TX_GAP   = 3'd4
	} tx_state_e;

	// receiver frame sequence.
	typedef enum logic [1:0] {
		RX_IDLE  = 2'd0,
		RX_START = 2'd1,
		RX_DATA  = 2'd2,
		RX_STOP  = 2'd3
	} rx_state_e;

endpackage

//--- host_pkg.sv
// Host endpoint package with the command opcodes and the status word layout.
package host_pkg;

	// opcode sits in the low bits of the command word.
	localparam int OPCODE_W = 4;

	// the rising edge of this bit runs the command.
	localparam int TRIG_BIT = 15;

	// commands the host can issue.
	typedef enum logic [OPCODE_W-1:0] {
		CMD_NOP   = 4'h0,
		CMD_LOAD  = 4'h1,
		CMD_SEND  = 4'h2,
		CMD_READ  = 4'h3,
		CMD_CLEAR = 4'h4
	} cmd_e;

	// status word bit positions.
	localparam int ST_BT_STATE = 0;
	localparam int ST_TX_BUSY  = 1;
	localparam int ST_TX_EMPTY = 2;
	localparam int ST_RX_EMPTY = 3;

endpackage

//--- uart_byte_if.sv
// Byte channel bundle between the link control and the UART transmitter and receiver.
`timescale 1ns/1ps

interface uart_byte_if;

	// transmit channel.
	link_pkg::byte_t tx_data;
	logic tx_start;
	logic tx_busy;

	// receive channel, valid and err are single cycle pulses.
	link_pkg::byte_t rx_data;
	logic rx_valid;
	logic rx_err;

	modport ctrl (
		output tx_data, tx_start,
		input tx_busy, rx_data, rx_valid, rx_err
	);

	modport tx (
		input tx_data, tx_start,
		output tx_busy
	);

	modport rx (
		output rx_data, rx_valid, rx_err
	);

endinterface

//--- uart_tx.sv
// UART transmitter with a runtime bit period and an idle gap after each byte.
`timescale 1ns/1ps

module uart_tx (
	input logic clock,
	input logic rst_n,
	input link_pkg::cpd_t cpd,
	input link_pkg::cpd_t spacing,
	uart_byte_if.tx bus,
	output logic txd
);

	link_pkg::tx_state_e state;
	link_pkg::cpd_t cnt;
	logic [link_pkg::BIT_IDX_W-1:0] idx;
	link_pkg::byte_t shift;
	logic bit_end;

	assign bit_end = (cnt == cpd - 1'b1);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= link_pkg::TX_IDLE;
			cnt <= '0;
			idx <= '0;
		end else begin
			case (state)
				link_pkg::TX_IDLE: begin
					if (bus.tx_start) begin
						state <= link_pkg::TX_START;
						cnt <= '0;
					end
				end
				link_pkg::TX_START: begin
					if (bit_end) begin
						state <= link_pkg::TX_DATA;
						cnt <= '0;
						idx <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				link_pkg::TX_DATA: begin
					if (bit_end) begin
						cnt <= '0;
						if (idx == link_pkg::BIT_IDX_W'(link_pkg::DATA_BITS - 1))
							state <= link_pkg::TX_STOP;
						else
							idx <= idx + 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				link_pkg::TX_STOP: begin
					if (bit_end) begin
						cnt <= '0;
						// no gap requested, go straight back to idle.
						if (spacing == '0)
							state <= link_pkg::TX_IDLE;
						else
							state <= link_pkg::TX_GAP;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				link_pkg::TX_GAP: begin
					if (cnt == spacing - 1'b1)
						state <= link_pkg::TX_IDLE;
					else
						cnt <= cnt + 1'b1;
				end
				default: state <= link_pkg::TX_IDLE;
			endcase
		end
	end

	// frame shifter, lsb goes out first.
	always_ff @(posedge clock) begin
		if (state == link_pkg::TX_IDLE && bus.tx_start)
			shift <= bus.tx_data;
		else if (state == link_pkg::TX_DATA && bit_end)
			shift <= shift >> 1;
	end

	always_comb begin
		case (state)
			link_pkg::TX_START: txd = 1'b0;
			link_pkg::TX_DATA:  txd = shift[0];
			default:            txd = 1'b1;
		endcase
	end

	// busy covers the frame and the spacing gap.
	assign bus.tx_busy = (state != link_pkg::TX_IDLE);

endmodule

//--- uart_rx.sv
// UART receiver with a two flop synchronizer, mid-bit sampling and a stop bit check.
`timescale 1ns/1ps

module uart_rx (
	input logic clock,
	input logic rst_n,
	input link_pkg::cpd_t cpd,
	input logic rxd,
	uart_byte_if.rx bus
);

	logic rxd_s1, rxd_s2, rxd_prev;
	logic fall;
	link_pkg::rx_state_e state;
	link_pkg::cpd_t cnt;
	logic [link_pkg::BIT_IDX_W-1:0] idx;
	link_pkg::byte_t shift;
	logic bit_end;

	// line idles high.
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rxd_s1 <= 1'b1;
			rxd_s2 <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_s1 <= rxd;
			rxd_s2 <= rxd_s1;
			rxd_prev <= rxd_s2;
		end
	end

	assign fall = rxd_prev & ~rxd_s2;
	assign bit_end = (cnt == cpd - 1'b1);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= link_pkg::RX_IDLE;
			cnt <= '0;
			idx <= '0;
			bus.rx_valid <= 1'b0;
			bus.rx_err <= 1'b0;
		end else begin
			bus.rx_valid <= 1'b0;
			bus.rx_err <= 1'b0;
			case (state)
				link_pkg::RX_IDLE: begin
					if (fall) begin
						state <= link_pkg::RX_START;
						cnt <= '0;
					end
				end
				link_pkg::RX_START: begin
					// half a period in, the start bit must still be low.
					if (cnt == (cpd >> 1)) begin
						cnt <= '0;
						idx <= '0;
						if (!rxd_s2)
							state <= link_pkg::RX_DATA;
						else
							state <= link_pkg::RX_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				link_pkg::RX_DATA: begin
					if (bit_end) begin
						cnt <= '0;
						if (idx == link_pkg::BIT_IDX_W'(link_pkg::DATA_BITS - 1))
							state <= link_pkg::RX_STOP;
						else
							idx <= idx + 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				link_pkg::RX_STOP: begin
					if (bit_end) begin
						cnt <= '0;
						state <= link_pkg::RX_IDLE;
						bus.rx_valid <= rxd_s2;
						bus.rx_err <= ~rxd_s2;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= link_pkg::RX_IDLE;
			endcase
		end
	end

	// data arrives lsb first, shift in from the top.
	always_ff @(posedge clock) begin
		if (state == link_pkg::RX_DATA && bit_end)
			shift <= {rxd_s2, shift[link_pkg::DATA_BITS-1:1]};
	end

	assign bus.rx_data = shift;

endmodule

//--- msg_buffer.sv
// Synchronous byte FIFO with a fill count and a clear input.
`timescale 1ns/1ps

module msg_buffer #(
	parameter int FIFO_DEPTH = 16
) (
	input logic clock,
	input logic rst_n,
	input logic clear,
	input logic push,
	input logic [7:0] wdata,
	input logic pop,
	output logic [7:0] rdata,
	output logic [$clog2(FIFO_DEPTH):0] count,
	output logic empty,
	output logic full
);

	localparam int AW = $clog2(FIFO_DEPTH);

	logic [7:0] mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr, rd_ptr;
	logic do_push, do_pop;

	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// push and pop together leave the count alone.
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push && !clear)
			mem[wr_ptr] <= wdata;
	end

	// head entry is visible without a pop.
	assign rdata = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == (AW + 1)'(FIFO_DEPTH));

endmodule

//--- bt_link_ctrl.sv
// Link control that decodes host commands and moves bytes among the host, FIFOs and UART.
`timescale 1ns/1ps

module bt_link_ctrl #(
	parameter int FIFO_DEPTH = 16
) (
	input logic clock,
	input logic rst_n,
	input logic bt_state,
	input logic [15:0] cmd_word,
	input logic [15:0] data_word,
	uart_byte_if.ctrl bus,
	output logic tx_push,
	output logic [7:0] tx_wdata,
	output logic tx_pop,
	input logic [7:0] tx_rdata,
	input logic tx_empty,
	input logic tx_full,
	output logic rx_push,
	output logic [7:0] rx_wdata,
	output logic rx_pop,
	input logic [7:0] rx_rdata,
	input logic rx_empty,
	input logic rx_full,
	output logic buf_clear,
	output logic [7:0] last_byte,
	output logic [15:0] err_count,
	output logic [15:0] status
);

	logic trig_s1, trig_s2, trig_q;
	logic cmd_fire;
	host_pkg::cmd_e opcode;
	logic do_load, do_send, do_read;
	logic sending;
	logic feed;
	logic load_drop, rx_drop, send_refused;
	logic [2:0] err_inc;
	logic [16:0] err_sum;

	// trigger comes from the host clock domain.
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			trig_s1 <= 1'b0;
			trig_s2 <= 1'b0;
			trig_q <= 1'b0;
		end else begin
			trig_s1 <= cmd_word[host_pkg::TRIG_BIT];
			trig_s2 <= trig_s1;
			trig_q <= trig_s2;
		end
	end

	assign cmd_fire = trig_s2 & ~trig_q;
	assign opcode = host_pkg::cmd_e'(cmd_word[host_pkg::OPCODE_W-1:0]);

	always_comb begin
		do_load = 1'b0;
		do_send = 1'b0;
		do_read = 1'b0;
		buf_clear = 1'b0;
		case (opcode)
			host_pkg::CMD_LOAD:  do_load = cmd_fire;
			host_pkg::CMD_SEND:  do_send = cmd_fire;
			host_pkg::CMD_READ:  do_read = cmd_fire;
			host_pkg::CMD_CLEAR: buf_clear = cmd_fire;
			host_pkg::CMD_NOP: ;
			default: ;
		endcase
	end

	assign tx_push = do_load & ~tx_full;
	assign tx_wdata = data_word[7:0];
	assign load_drop = do_load & tx_full;
	assign rx_pop = do_read & ~rx_empty;
	assign send_refused = do_send & ~bt_state;

	// a send keeps feeding until the tx buffer drains.
	assign feed = sending & ~tx_empty & ~bus.tx_busy & ~bus.tx_start & ~buf_clear;
	assign tx_pop = feed;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			sending <= 1'b0;
		else if (buf_clear)
			sending <= 1'b0;
		else if (do_send && bt_state)
			sending <= 1'b1;
		else if (tx_empty)
			sending <= 1'b0;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			bus.tx_start <= 1'b0;
		else
			bus.tx_start <= feed;
	end

	always_ff @(posedge clock) begin
		if (feed)
			bus.tx_data <= tx_rdata;
	end

	// every received byte goes to the rx buffer if it has room.
	assign rx_push = bus.rx_valid & ~rx_full;
	assign rx_wdata = bus.rx_data;
	assign rx_drop = bus.rx_valid & rx_full;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			last_byte <= '0;
		else if (rx_pop)
			last_byte <= rx_rdata;
	end

	// several error sources can fire in the same cycle.
	assign err_inc = 3'(load_drop) + 3'(send_refused) + 3'(rx_drop) + 3'(bus.rx_err);
	assign err_sum = {1'b0, err_count} + 17'(err_inc);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			err_count <= '0;
		else if (buf_clear)
			err_count <= '0;
		else if (err_sum[16])
			err_count <= '1;
		else
			err_count <= err_sum[15:0];
	end

	always_comb begin
		status = '0;
		status[host_pkg::ST_BT_STATE] = bt_state;
		status[host_pkg::ST_TX_BUSY] = bus.tx_busy;
		status[host_pkg::ST_TX_EMPTY] = tx_empty;
		status[host_pkg::ST_RX_EMPTY] = rx_empty;
	end

endmodule

//--- bt_link_top.sv
// Bluetooth serial link top: FIFOs, UART pair and link control on plain endpoint ports.
`timescale 1ns/1ps

module bt_link_top #(
	parameter int FIFO_DEPTH = 16
) (
	input logic clock,
	input logic rst_n,
	input logic bt_state,
	input logic bt_txd,
	output logic bt_rxd,
	input link_pkg::cpd_t uart_cpd,
	input link_pkg::cpd_t uart_spacing_limit,
	input logic [15:0] ep01_wire_in,
	input logic [15:0] ep02_wire_in,
	output logic [15:0] ep20_wire_out,
	output logic [15:0] ep21_wire_out,
	output logic [15:0] ep22_wire_out,
	output logic [15:0] ep23_wire_out,
	output logic [15:0] ep24_wire_out,
	output logic [7:0] lights
);

	localparam int CW = $clog2(FIFO_DEPTH) + 1;

	uart_byte_if ubus ();

	logic tx_push, tx_pop, tx_empty, tx_full;
	logic rx_push, rx_pop, rx_empty, rx_full;
	logic [7:0] tx_wdata, tx_rdata, rx_wdata, rx_rdata;
	logic [CW-1:0] tx_count, rx_count;
	logic buf_clear;
	logic [7:0] last_byte;

	// the module's rx pin is our transmit line.
	uart_tx tx_uart (
		.clock(clock),
		.rst_n(rst_n),
		.cpd(uart_cpd),
		.spacing(uart_spacing_limit),
		.bus(ubus.tx),
		.txd(bt_rxd)
	);

	uart_rx rx_uart (
		.clock(clock),
		.rst_n(rst_n),
		.cpd(uart_cpd),
		.rxd(bt_txd),
		.bus(ubus.rx)
	);

	msg_buffer #(.FIFO_DEPTH(FIFO_DEPTH)) tx_buf (
		.clock(clock), .rst_n(rst_n), .clear(buf_clear),
		.push(tx_push), .wdata(tx_wdata), .pop(tx_pop), .rdata(tx_rdata),
		.count(tx_count), .empty(tx_empty), .full(tx_full)
	);

	msg_buffer #(.FIFO_DEPTH(FIFO_DEPTH)) rx_buf (
		.clock(clock), .rst_n(rst_n), .clear(buf_clear),
		.push(rx_push), .wdata(rx_wdata), .pop(rx_pop), .rdata(rx_rdata),
		.count(rx_count), .empty(rx_empty), .full(rx_full)
	);

	bt_link_ctrl #(.FIFO_DEPTH(FIFO_DEPTH)) ctrl (
		.clock(clock), .rst_n(rst_n), .bt_state(bt_state),
		.cmd_word(ep02_wire_in), .data_word(ep01_wire_in), .bus(ubus.ctrl),
		.tx_push(tx_push), .tx_wdata(tx_wdata), .tx_pop(tx_pop), .tx_rdata(tx_rdata),
		.tx_empty(tx_empty), .tx_full(tx_full),
		.rx_push(rx_push), .rx_wdata(rx_wdata), .rx_pop(rx_pop), .rx_rdata(rx_rdata),
		.rx_empty(rx_empty), .rx_full(rx_full),
		.buf_clear(buf_clear), .last_byte(last_byte),
		.err_count(ep24_wire_out), .status(ep20_wire_out)
	);

	assign ep21_wire_out = {8'h00, last_byte};
	assign ep22_wire_out = {{(16 - CW){1'b0}}, tx_count};
	assign ep23_wire_out = {{(16 - CW){1'b0}}, rx_count};

	// lights are active low: rx fill on top, tx fill below.
	assign lights = ~{rx_count[3:0], tx_count[3:0]};

endmodule

//--- tb_bt_link.sv
// Testbench for the Bluetooth serial link with host commands, a UART line model and assertions.
`timescale 1ns/1ps

module tb_bt_link;

	localparam int FIFO_DEPTH = 16;
	localparam int CPD = 8;
	localparam int SPACING = 5;

	logic clock;
	logic rst_n;
	logic bt_state;
	logic bt_txd;
	logic bt_rxd;
	link_pkg::cpd_t uart_cpd;
	link_pkg::cpd_t uart_spacing_limit;
	logic [15:0] ep01_wire_in;
	logic [15:0] ep02_wire_in;
	logic [15:0] ep20_wire_out;
	logic [15:0] ep21_wire_out;
	logic [15:0] ep22_wire_out;
	logic [15:0] ep23_wire_out;
	logic [15:0] ep24_wire_out;
	logic [7:0] lights;

	int errors = 0;
	int frames_seen = 0;
	logic timed_out = 1'b0;
	logic [31:0] seed;

	// bytes expected on bt_rxd and bytes expected back from the rx buffer.
	logic [7:0] exp_tx_q[$];
	logic [7:0] rx_q[$];

	bt_link_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (
		.clock(clock),
		.rst_n(rst_n),
		.bt_state(bt_state),
		.bt_txd(bt_txd),
		.bt_rxd(bt_rxd),
		.uart_cpd(uart_cpd),
		.uart_spacing_limit(uart_spacing_limit),
		.ep01_wire_in(ep01_wire_in),
		.ep02_wire_in(ep02_wire_in),
		.ep20_wire_out(ep20_wire_out),
		.ep21_wire_out(ep21_wire_out),
		.ep22_wire_out(ep22_wire_out),
		.ep23_wire_out(ep23_wire_out),
		.ep24_wire_out(ep24_wire_out),
		.lights(lights)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// active low lights follow the rx and tx fill nibbles.
	lights_track: assert property (@(posedge clock) disable iff (!rst_n)
		lights == ~{ep23_wire_out[3:0], ep22_wire_out[3:0]})
		else begin
			errors++;
			$display("Fail %0t: lights do not match the fill counts", $time);
		end

	state_track: assert property (@(posedge clock) disable iff (!rst_n)
		ep20_wire_out[host_pkg::ST_BT_STATE] == bt_state)
		else begin
			errors++;
			$display("Fail %0t: status bit 0 does not follow bt_state", $time);
		end

	// empty flags in the status word follow the fill counts.
	empty_track: assert property (@(posedge clock) disable iff (!rst_n)
		ep20_wire_out[host_pkg::ST_TX_EMPTY] == (ep22_wire_out == 16'd0)
		&& ep20_wire_out[host_pkg::ST_RX_EMPTY] == (ep23_wire_out == 16'd0))
		else begin
			errors++;
			$display("Fail %0t: status empty flags do not match the fill counts", $time);
		end

	// a low line means a frame is on the way out.
	busy_track: assert property (@(posedge clock) disable iff (!rst_n)
		!bt_rxd |-> ep20_wire_out[host_pkg::ST_TX_BUSY])
		else begin
			errors++;
			$display("Fail %0t: status tx_busy is low while a frame is sent", $time);
		end

	function automatic logic [7:0] next_rand_byte();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[23:16];
	endfunction

	task automatic end_run();
		$display("errors %0d, frames decoded %0d", errors, frames_seen);
		if (errors == 0 && !timed_out)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	endtask

	task automatic give_up(input string what);
		$display("timeout while waiting for %s", what);
		timed_out = 1'b1;
		end_run();
	endtask

	task automatic expect_word(input string what, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp)
		else begin
			errors++;
			$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// trigger rises one cycle after the opcode settles and stays high past the edge flop.
	task automatic run_cmd(input host_pkg::cmd_e op, input logic [7:0] data);
		@(negedge clock);
		ep01_wire_in = {8'h00, data};
		ep02_wire_in = 16'(op);
		@(negedge clock);
		ep02_wire_in[host_pkg::TRIG_BIT] = 1'b1;
		repeat (4) @(negedge clock);
		ep02_wire_in[host_pkg::TRIG_BIT] = 1'b0;
		repeat (3) @(negedge clock);
	endtask

	// drives one frame onto bt_txd lsb first and then idles for two bit times.
	task automatic drive_frame(input logic [7:0] data, input logic stop_bit);
		@(negedge clock);
		bt_txd = 1'b0;
		repeat (CPD) @(negedge clock);
		for (int i = 0; i < 8; i++) begin
			bt_txd = data[i];
			repeat (CPD) @(negedge clock);
		end
		bt_txd = stop_bit;
		repeat (CPD) @(negedge clock);
		bt_txd = 1'b1;
		repeat (2 * CPD) @(negedge clock);
	endtask

	task automatic wait_rx_count(input logic [15:0] exp, input int limit);
		int n;
		n = 0;
		while (ep23_wire_out != exp) begin
			@(negedge clock);
			n++;
			if (n > limit)
				give_up("the rx count");
		end
	endtask

	task automatic wait_err_count(input logic [15:0] exp, input int limit);
		int n;
		n = 0;
		while (ep24_wire_out != exp) begin
			@(negedge clock);
			n++;
			if (n > limit)
				give_up("the error count");
		end
	endtask

	// a send is over once every frame is decoded and the transmitter is idle and empty.
	task automatic wait_send_done(input int limit);
		int n;
		n = 0;
		while (exp_tx_q.size() != 0 || ep20_wire_out[host_pkg::ST_TX_BUSY]
				|| !ep20_wire_out[host_pkg::ST_TX_EMPTY]) begin
			@(negedge clock);
			n++;
			if (n > limit)
				give_up("the send to finish");
		end
	endtask

	task automatic check_idle(input string when);
		expect_word({"tx count ", when}, ep22_wire_out, 16'd0);
		expect_word({"rx count ", when}, ep23_wire_out, 16'd0);
		expect_word({"error count ", when}, ep24_wire_out, 16'd0);
		expect_word({"lights ", when}, {8'h00, lights}, 16'h00ff);
	endtask

	// decodes bt_rxd at mid-bit and measures the idle run before each start bit.
	initial begin : line_monitor
		int high_run;
		logic gap_valid;
		logic start_bit;
		logic stop_bit;
		logic [7:0] got;
		high_run = 0;
		gap_valid = 1'b0;
		forever begin
			@(negedge clock);
			if (rst_n && bt_rxd) begin
				high_run++;
			end else if (rst_n) begin
				if (gap_valid) begin
					assert (high_run >= SPACING)
					else begin
						errors++;
						$display("Fail %0t: idle gap of %0d cycles, expected at least %0d",
							$time, high_run, SPACING);
					end
				end
				repeat (CPD / 2) @(negedge clock);
				start_bit = bt_rxd;
				for (int i = 0; i < 8; i++) begin
					repeat (CPD) @(negedge clock);
					got[i] = bt_rxd;
				end
				repeat (CPD) @(negedge clock);
				stop_bit = bt_rxd;
				repeat (CPD - CPD / 2 - 1) @(negedge clock);
				frames_seen++;
				high_run = 0;
				gap_valid = 1'b1;
				assert (start_bit == 1'b0)
				else begin
					errors++;
					$display("Fail %0t: start bit of sent frame is high", $time);
				end
				assert (stop_bit == 1'b1)
				else begin
					errors++;
					$display("Fail %0t: stop bit of sent frame is low", $time);
				end
				assert (exp_tx_q.size() != 0)
				else begin
					errors++;
					$display("Fail %0t: unexpected frame %h on bt_rxd", $time, got);
				end
				if (exp_tx_q.size() != 0) begin
					assert (got == exp_tx_q[0])
					else begin
						errors++;
						$display("Fail %0t: sent byte %h, expected %h", $time, got, exp_tx_q[0]);
					end
					void'(exp_tx_q.pop_front());
				end
			end
		end
	end

	initial begin : stimulus
		logic [7:0] b;
		logic [15:0] err_base;
		int frames_base;
		seed = 32'h26b2_a657;
		rst_n = 1'b0;
		bt_state = 1'b0;
		bt_txd = 1'b1;
		uart_cpd = 10'(CPD);
		uart_spacing_limit = 10'(SPACING);
		ep01_wire_in = 16'h0000;
		ep02_wire_in = 16'h0000;
		repeat (16) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		@(negedge clock);
		check_idle("after reset");

		// connected send of random bytes.
		bt_state = 1'b1;
		for (int i = 0; i < 6; i++) begin
			b = next_rand_byte();
			exp_tx_q.push_back(b);
			run_cmd(host_pkg::CMD_LOAD, b);
		end
		expect_word("tx count after loads", ep22_wire_out, 16'd6);
		frames_base = frames_seen;
		run_cmd(host_pkg::CMD_SEND, 8'h00);
		wait_send_done(3000);
		expect_word("tx count after send", ep22_wire_out, 16'd0);
		expect_word("frames sent", 16'(frames_seen - frames_base), 16'd6);

		// receive random bytes and read them back oldest first.
		for (int i = 0; i < 5; i++) begin
			b = next_rand_byte();
			rx_q.push_back(b);
			drive_frame(b, 1'b1);
			wait_rx_count(16'(i + 1), 400);
		end
		for (int i = 5; i > 0; i--) begin
			run_cmd(host_pkg::CMD_READ, 8'h00);
			b = rx_q.pop_front();
			expect_word("last byte read", ep21_wire_out, {8'h00, b});
			expect_word("rx count after read", ep23_wire_out, 16'(i - 1));
		end

		// low stop bit is a framing error.
		err_base = ep24_wire_out;
		drive_frame(next_rand_byte(), 1'b0);
		wait_err_count(err_base + 16'd1, 400);
		expect_word("rx count after framing error", ep23_wire_out, 16'd0);

		// three loads past a full tx buffer.
		err_base = ep24_wire_out;
		for (int i = 0; i < FIFO_DEPTH + 3; i++)
			run_cmd(host_pkg::CMD_LOAD, next_rand_byte());
		expect_word("tx count when full", ep22_wire_out, 16'(FIFO_DEPTH));
		expect_word("error count after overfill", ep24_wire_out, err_base + 16'd3);
		run_cmd(host_pkg::CMD_CLEAR, 8'h00);
		check_idle("after clear");

		// send refused while the module is disconnected.
		bt_state = 1'b0;
		run_cmd(host_pkg::CMD_LOAD, next_rand_byte());
		run_cmd(host_pkg::CMD_LOAD, next_rand_byte());
		frames_base = frames_seen;
		err_base = ep24_wire_out;
		run_cmd(host_pkg::CMD_SEND, 8'h00);
		for (int i = 0; i < 12 * CPD; i++) begin
			@(negedge clock);
			assert (bt_rxd == 1'b1)
			else begin
				errors++;
				$display("Fail %0t: bt_rxd went low while disconnected", $time);
			end
		end
		expect_word("frames while disconnected", 16'(frames_seen - frames_base), 16'd0);
		expect_word("error count after refused send", ep24_wire_out, err_base + 16'd1);
		expect_word("tx count after refused send", ep22_wire_out, 16'd2);
		run_cmd(host_pkg::CMD_CLEAR, 8'h00);
		check_idle("after second clear");

		end_run();
	end

endmodule

//--- compile.f
link_pkg.sv
host_pkg.sv
uart_byte_if.sv
uart_tx.sv
uart_rx.sv
msg_buffer.sv
bt_link_ctrl.sv
bt_link_top.sv
tb_bt_link.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_bt_link
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= sim passed

SOURCES := $(shell cat $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
